// File: mask_unit.f
+incdir+verif
src/masku_pkg.sv
src/masku_insn_ctrl.sv
src/masku_mask_queue.sv
src/masku_result_queue.sv
src/masku_top.sv
verif/tb_masku.sv

// File: Bender.yml
package:
  name: mask_unit

sources:
  - files:
      - src/masku_pkg.sv
      - src/masku_insn_ctrl.sv
      - src/masku_mask_queue.sv
      - src/masku_result_queue.sv
      - src/masku_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_masku.sv

// File: verif/tb_masku_pkg.svh
`ifndef TB_MASKU_PKG_SVH
`define TB_MASKU_PKG_SVH

////////////////////
// Random source
////////////////////

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] take_bits(input int unsigned n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// One flat word across all lanes
function automatic logic [WordBits-1:0] rand_word();
  logic [WordBits-1:0] word;
  for (int unsigned i = 0; i < WordBits / 32; i++) begin
    word[i*32 +: 32] = take_bits(32);
  end
  return word;
endfunction

////////////////////
// Reference model
////////////////////

// Bits still inside the vector length take a, the tail keeps b
function automatic logic [WordBits-1:0] ref_merge(input logic [WordBits-1:0] a,
                                                  input logic [WordBits-1:0] b,
                                                  input int unsigned remaining);
  logic [WordBits-1:0] res;
  for (int unsigned i = 0; i < WordBits; i++) begin
    res[i] = (i < remaining) ? a[i] : b[i];
  end
  return res;
endfunction

// Elements sit in sequence across the lanes
// Element e reads mask bit e of the concatenated mask words
function automatic strb_t ref_strobe(input logic [WordBits-1:0] word, input int unsigned beat,
                                     input int unsigned vsew, input int unsigned lane,
                                     input int unsigned vl);
  strb_t       strb;
  int unsigned per_beat;
  int unsigned elem;
  per_beat = (NrLanes * ELENB) >> vsew;
  for (int unsigned i = 0; i < ELENB; i++) begin
    elem    = beat * per_beat + ((lane * ELENB + i) >> vsew);
    strb[i] = (elem < vl) ? word[elem % WordBits] : 1'b0;
  end
  return strb;
endfunction

// Single compare point for every expected value
task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

`endif

// File: verif/tb_masku.sv
`default_nettype none

module tb_masku;

  import masku_pkg::*;

  localparam int unsigned NrLanes  = 4;
  localparam int unsigned WordBits = NrLanes * ELEN;
  localparam int unsigned MaxBeats = 16;
  localparam int unsigned NumInsns = 12;
  localparam logic [31:0] Seed     = 32'h2990afbf;

  logic                  clk_i;
  logic                  rst_ni;
  pe_req_t               pe_req_i;
  logic                  pe_req_valid_i;
  logic                  pe_req_ready_o;
  logic [NrVInsn-1:0]    pe_vinsn_running_i;
  logic [NrVInsn-1:0]    pe_done_o;
  elen_t [NrLanes-1:0]   operand_a_i;
  elen_t [NrLanes-1:0]   operand_b_i;
  elen_t [NrLanes-1:0]   operand_m_i;
  logic [NrLanes-1:0]    operand_a_valid_i, operand_a_ready_o;
  logic [NrLanes-1:0]    operand_b_valid_i, operand_b_ready_o;
  logic [NrLanes-1:0]    operand_m_valid_i, operand_m_ready_o;
  result_t [NrLanes-1:0] result_o;
  logic [NrLanes-1:0]    result_req_o, result_gnt_i;
  strb_t [NrLanes-1:0]   mask_o;
  logic [NrLanes-1:0]    mask_valid_o, lane_mask_ready_i;
  logic                  unit_mask_ready_i;

  // Stimulus of the current instruction and progress counters
  logic [31:0]         lfsr_q;
  logic [WordBits-1:0] a_mem [MaxBeats];
  logic [WordBits-1:0] b_mem [MaxBeats];
  logic [WordBits-1:0] m_mem [MaxBeats];
  pe_req_t             cur;
  int unsigned         res_beats, mask_beats, m_words;
  int unsigned         ab_idx, m_idx;
  int unsigned         res_cnt [NrLanes];
  int unsigned         mask_cnt [NrLanes];

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  `include "tb_masku_pkg.svh"

  masku_top #(
    .NrLanes (NrLanes)
  ) u_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_req_i           (pe_req_i),
    .pe_req_valid_i     (pe_req_valid_i),
    .pe_req_ready_o     (pe_req_ready_o),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .pe_done_o          (pe_done_o),
    .operand_a_i        (operand_a_i),
    .operand_a_valid_i  (operand_a_valid_i),
    .operand_a_ready_o  (operand_a_ready_o),
    .operand_b_i        (operand_b_i),
    .operand_b_valid_i  (operand_b_valid_i),
    .operand_b_ready_o  (operand_b_ready_o),
    .operand_m_i        (operand_m_i),
    .operand_m_valid_i  (operand_m_valid_i),
    .operand_m_ready_o  (operand_m_ready_o),
    .result_o           (result_o),
    .result_req_o       (result_req_o),
    .result_gnt_i       (result_gnt_i),
    .mask_o             (mask_o),
    .mask_valid_o       (mask_valid_o),
    .lane_mask_ready_i  (lane_mask_ready_i),
    .unit_mask_ready_i  (unit_mask_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Budget of 200 cycles for each instruction
  initial begin : watchdog
    repeat (NumInsns * 200) @(posedge clk_i);
    abort_run($sformatf("Watchdog expired after %0d cycles, the tests did not finish",
                        NumInsns * 200));
  end

  ////////////////////
  // Lane, register file and consumer models
  ////////////////////

  always @(posedge clk_i) begin : lane_models
    if (rst_ni) begin
      // A beat takes a and b from every lane at once, and only when all are valid
      if (|operand_a_ready_o || |operand_b_ready_o) begin
        check_val("operand_a_ready_o", operand_a_ready_o,
                  {NrLanes{&operand_a_valid_i && &operand_b_valid_i}});
        check_val("operand_b_ready_o", operand_b_ready_o,
                  {NrLanes{&operand_a_valid_i && &operand_b_valid_i}});
        ab_idx = ab_idx + 1;
        operand_a_valid_i <= '0;
        operand_b_valid_i <= '0;
      end else if (ab_idx < res_beats) begin
        operand_a_i       <= a_mem[ab_idx];
        operand_b_i       <= b_mem[ab_idx];
        operand_a_valid_i <= operand_a_valid_i | NrLanes'(take_bits(NrLanes));
        operand_b_valid_i <= operand_b_valid_i | NrLanes'(take_bits(NrLanes));
      end
      // Mask word stays put until the unit releases it
      if (|operand_m_ready_o) begin
        m_idx = m_idx + 1;
        operand_m_valid_i <= '0;
      end else if (m_idx < m_words) begin
        operand_m_i       <= m_mem[m_idx];
        operand_m_valid_i <= operand_m_valid_i | NrLanes'(take_bits(NrLanes));
      end
      result_gnt_i      <= result_req_o & NrLanes'(take_bits(NrLanes));
      lane_mask_ready_i <= NrLanes'(take_bits(NrLanes));
      unit_mask_ready_i <= (take_bits(3) == 0);
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  always @(posedge clk_i) begin : compare
    logic [WordBits-1:0] exp_res;
    int unsigned         k;
    int unsigned         per_beat;
    if (rst_ni) begin
      for (int unsigned l = 0; l < NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          k = res_cnt[l];
          if (k >= res_beats) begin
            abort_run($sformatf("Lane %0d wrote a result past the last beat", l));
          end else begin
            exp_res = ref_merge(a_mem[k], b_mem[k], cur.vl - k * WordBits);
            check_val("result_o.wdata", result_o[l].wdata, exp_res[l*ELEN +: ELEN]);
            check_val("result_o.addr", result_o[l].addr, cur.vd * VRegWords + k);
            check_val("result_o.id", result_o[l].id, cur.id);
            check_val("result_o.be", result_o[l].be, 8'hff);
            res_cnt[l] = k + 1;
          end
        end
        if (mask_valid_o[l] && (lane_mask_ready_i[l] || unit_mask_ready_i)) begin
          k        = mask_cnt[l];
          per_beat = (NrLanes * ELENB) >> cur.vsew;
          if (k >= mask_beats) begin
            abort_run($sformatf("Lane %0d got a mask strobe past the last beat", l));
          end else begin
            check_val("mask_o", mask_o[l],
                      ref_strobe(m_mem[k * per_beat / WordBits], k, cur.vsew, l, cur.vl));
            mask_cnt[l] = k + 1;
          end
        end
      end
    end
  end

  ////////////////////
  // Sequencer
  ////////////////////

  // Runs one instruction from request to done pulse
  task automatic run_insn(input vid_t id, input vfu_e vfu, input vew_e vsew,
                          input logic [4:0] vd, input int unsigned vl,
                          input bit hold_flag, input int unsigned block_cycles);
    pe_req_t     req;
    int unsigned per_beat;
    @(negedge clk_i);
    req.id   = id;
    req.vfu  = vfu;
    req.vsew = vsew;
    req.vm   = (vfu == VFU_MASKU);
    req.vd   = vd;
    req.vl   = vlen_t'(vl);
    cur      = req;
    per_beat = (NrLanes * ELENB) >> vsew;
    for (int unsigned k = 0; k < MaxBeats; k++) begin
      a_mem[k] = rand_word();
      b_mem[k] = rand_word();
      m_mem[k] = rand_word();
    end
    // Mask unit ops write results, the others only need strobes
    res_beats  = (vfu == VFU_MASKU) ? (vl + WordBits - 1) / WordBits : 0;
    mask_beats = (vfu == VFU_MASKU) ? 0 : (vl + per_beat - 1) / per_beat;
    m_words    = (vfu == VFU_MASKU) ? 0 : (vl + WordBits - 1) / WordBits;
    ab_idx     = 0;
    m_idx      = 0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      res_cnt[l]  = 0;
      mask_cnt[l] = 0;
    end

    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    if (block_cycles == 0) begin
      pe_vinsn_running_i[id] <= 1'b1;
    end else begin
      // ID still flagged, nothing may be taken
      repeat (block_cycles) begin
        @(posedge clk_i);
        check_val("pe_req_ready_o", pe_req_ready_o, 1'b1);
      end
      pe_vinsn_running_i[id] <= 1'b0;
    end

    @(posedge clk_i);
    while (pe_req_ready_o) @(posedge clk_i);
    pe_req_valid_i <= 1'b0;

    // Held instruction keeps the intake closed
    @(posedge clk_i);
    while (pe_done_o == '0) begin
      check_val("pe_req_ready_o", pe_req_ready_o, 1'b0);
      @(posedge clk_i);
    end
    check_val("pe_done_o", pe_done_o, NrVInsn'(1) << id);
    for (int unsigned l = 0; l < NrLanes; l++) begin
      check_val("result_o count", res_cnt[l], res_beats);
      check_val("mask_o count", mask_cnt[l], mask_beats);
    end
    if (!hold_flag) begin
      pe_vinsn_running_i[id] <= 1'b0;
    end
    @(posedge clk_i);
    check_val("pe_done_o", pe_done_o, '0);
  endtask

  initial begin : stimulus
    rst_ni             = 1'b0;
    pe_req_i           = '0;
    pe_req_valid_i     = 1'b0;
    pe_vinsn_running_i = '0;
    operand_a_i        = '0;
    operand_b_i        = '0;
    operand_m_i        = '0;
    operand_a_valid_i  = '0;
    operand_b_valid_i  = '0;
    operand_m_valid_i  = '0;
    result_gnt_i       = '0;
    lane_mask_ready_i  = '0;
    unit_mask_ready_i  = 1'b0;
    lfsr_q             = Seed;
    res_beats          = 0;
    mask_beats         = 0;
    m_words            = 0;
    ab_idx             = 0;
    m_idx              = 0;

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_val("pe_req_ready_o", pe_req_ready_o, 1'b1);
    check_val("result_req_o", result_req_o, '0);
    check_val("mask_valid_o", mask_valid_o, '0);
    check_val("pe_done_o", pe_done_o, '0);
    check_val("operand_a_ready_o", operand_a_ready_o, '0);
    check_val("operand_b_ready_o", operand_b_ready_o, '0);
    check_val("operand_m_ready_o", operand_m_ready_o, '0);

    // Single beat with a tail
    run_insn(3'd0, VFU_MASKU, EW8, 5'd3, 77, 1'b0, 0);
    run_insn(3'd1, VFU_MASKU, EW32, 5'd10, 200, 1'b0, 0);
    // Several beats, merge only on the last
    run_insn(3'd2, VFU_MASKU, EW64, 5'd5, 700, 1'b0, 0);
    run_insn(3'd3, VFU_MASKU, EW8, 5'd31, 1024, 1'b0, 0);
    run_insn(3'd4, VFU_MASKU, EW16, 5'd7, 513, 1'b0, 0);
    // Strobes at every element width
    run_insn(3'd5, VFU_ALU, EW8, 5'd1, 300, 1'b0, 0);
    run_insn(3'd6, VFU_LOAD, EW16, 5'd2, 150, 1'b0, 0);
    run_insn(3'd7, VFU_ALU, EW32, 5'd4, 70, 1'b0, 0);
    run_insn(3'd0, VFU_LOAD, EW64, 5'd6, 37, 1'b0, 0);
    run_insn(3'd1, VFU_ALU, EW8, 5'd8, 256, 1'b0, 0);
    // Same ID again while the sequencer still flags it
    run_insn(3'd2, VFU_MASKU, EW8, 5'd9, 64, 1'b1, 0);
    run_insn(3'd2, VFU_ALU, EW16, 5'd11, 40, 1'b0, 10);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/masku_top.sv
`default_nettype none

module masku_top #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Sequencer
  input  masku_pkg::pe_req_t                  pe_req_i,
  input  logic                                pe_req_valid_i,
  output logic                                pe_req_ready_o,
  input  logic [masku_pkg::NrVInsn-1:0]       pe_vinsn_running_i,
  output logic [masku_pkg::NrVInsn-1:0]       pe_done_o,
  // Lane operands
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_a_i,
  input  logic [NrLanes-1:0]                  operand_a_valid_i,
  output logic [NrLanes-1:0]                  operand_a_ready_o,
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_b_i,
  input  logic [NrLanes-1:0]                  operand_b_valid_i,
  output logic [NrLanes-1:0]                  operand_b_ready_o,
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_m_i,
  input  logic [NrLanes-1:0]                  operand_m_valid_i,
  output logic [NrLanes-1:0]                  operand_m_ready_o,
  // Register file
  output masku_pkg::result_t [NrLanes-1:0]    result_o,
  output logic [NrLanes-1:0]                  result_req_o,
  input  logic [NrLanes-1:0]                  result_gnt_i,
  // Mask consumers
  output masku_pkg::strb_t [NrLanes-1:0]      mask_o,
  output logic [NrLanes-1:0]                  mask_valid_o,
  input  logic [NrLanes-1:0]                  lane_mask_ready_i,
  input  logic                                unit_mask_ready_i
);

  import masku_pkg::*;

  // Held instruction and its remaining counts
  pe_req_t insn;
  logic    insn_valid;
  vlen_t   read_cnt;
  vlen_t   issue_cnt;

  // Queue progress pulses
  logic mask_beat;
  logic result_beat;
  logic mask_pop;
  logic result_pop;

  masku_insn_ctrl #(
    .NrLanes (NrLanes)
  ) u_insn_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_req_i           (pe_req_i),
    .pe_req_valid_i     (pe_req_valid_i),
    .pe_req_ready_o     (pe_req_ready_o),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .pe_done_o          (pe_done_o),
    .mask_beat_i        (mask_beat),
    .result_beat_i      (result_beat),
    .mask_pop_i         (mask_pop),
    .result_pop_i       (result_pop),
    .insn_o             (insn),
    .insn_valid_o       (insn_valid),
    .read_cnt_o         (read_cnt),
    .issue_cnt_o        (issue_cnt)
  );

  masku_mask_queue #(
    .NrLanes (NrLanes)
  ) u_mask_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_i            (insn),
    .insn_valid_i      (insn_valid),
    .read_cnt_i        (read_cnt),
    .operand_m_i       (operand_m_i),
    .operand_m_valid_i (operand_m_valid_i),
    .operand_m_ready_o (operand_m_ready_o),
    .mask_o            (mask_o),
    .mask_valid_o      (mask_valid_o),
    .lane_mask_ready_i (lane_mask_ready_i),
    .unit_mask_ready_i (unit_mask_ready_i),
    .mask_beat_o       (mask_beat),
    .mask_pop_o        (mask_pop)
  );

  masku_result_queue #(
    .NrLanes (NrLanes)
  ) u_result_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_i            (insn),
    .insn_valid_i      (insn_valid),
    .issue_cnt_i       (issue_cnt),
    .operand_a_i       (operand_a_i),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_i       (operand_b_i),
    .operand_b_valid_i (operand_b_valid_i),
    .operand_b_ready_o (operand_b_ready_o),
    .result_o          (result_o),
    .result_req_o      (result_req_o),
    .result_gnt_i      (result_gnt_i),
    .result_beat_o     (result_beat),
    .result_pop_o      (result_pop)
  );

endmodule

`default_nettype wire

// File: src/masku_result_queue.sv
`default_nettype none

module masku_result_queue #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Held instruction
  input  masku_pkg::pe_req_t                  insn_i,
  input  logic                                insn_valid_i,
  input  masku_pkg::vlen_t                    issue_cnt_i,
  // Computed value and old destination from the lanes
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_a_i,
  input  logic [NrLanes-1:0]                  operand_a_valid_i,
  output logic [NrLanes-1:0]                  operand_a_ready_o,
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_b_i,
  input  logic [NrLanes-1:0]                  operand_b_valid_i,
  output logic [NrLanes-1:0]                  operand_b_ready_o,
  // Register file writes
  output masku_pkg::result_t [NrLanes-1:0]    result_o,
  output logic [NrLanes-1:0]                  result_req_o,
  input  logic [NrLanes-1:0]                  result_gnt_i,
  // Progress to the controller
  output logic                                result_beat_o,
  output logic                                result_pop_o
);

  import masku_pkg::*;

  localparam int unsigned WordBits  = NrLanes * ELEN;
  localparam int unsigned BeatShift = $clog2(WordBits);
  localparam int unsigned PntWidth  = $clog2(ResultQueueDepth);
  localparam int unsigned CntWidth  = $clog2(ResultQueueDepth + 1);

  // Queue storage and per-lane requests
  result_t [ResultQueueDepth-1:0][NrLanes-1:0] queue_q;
  logic    [ResultQueueDepth-1:0][NrLanes-1:0] valid_d, valid_q;
  logic    [PntWidth-1:0]                      write_pnt_q;
  logic    [PntWidth-1:0]                      read_pnt_q;
  logic    [CntWidth-1:0]                      cnt_q;

  logic [WordBits-1:0]   a_flat;
  logic [WordBits-1:0]   b_flat;
  logic [WordBits-1:0]   bit_en;
  logic [WordBits-1:0]   merged;
  result_t [NrLanes-1:0] beat_entry;
  vlen_t                 beat_idx;
  vaddr_t                beat_addr;
  logic                  active;
  logic                  full;
  logic                  empty;
  logic                  pop;

  assign active = insn_valid_i && insn_i.vfu == VFU_MASKU;
  assign full   = (cnt_q == ResultQueueDepth);
  assign empty  = (cnt_q == '0);

  ////////////////////
  // Tail merge
  ////////////////////

  assign a_flat = operand_a_i;
  assign b_flat = operand_b_i;

  // Bits below the remaining count come from a
  // All of them once the count covers the word
  always_comb begin : p_bit_en
    for (int unsigned i = 0; i < WordBits; i++) begin
      bit_en[i] = (i < issue_cnt_i);
    end
  end

  assign merged = (a_flat & bit_en) | (b_flat & ~bit_en);

  // Words already issued give the offset into the register
  assign beat_idx  = vlen_t'((insn_i.vl - issue_cnt_i) >> BeatShift);
  assign beat_addr = vaddr_t'(vaddr_t'(insn_i.vd) * VRegWords + beat_idx);

  always_comb begin : p_entry
    for (int unsigned l = 0; l < NrLanes; l++) begin
      beat_entry[l].id    = insn_i.id;
      beat_entry[l].addr  = beat_addr;
      beat_entry[l].wdata = merged[l*ELEN +: ELEN];
      beat_entry[l].be    = '1;
    end
  end

  // A beat needs every lane's a and b at once
  assign result_beat_o     = active && !full && &operand_a_valid_i && &operand_b_valid_i;
  assign operand_a_ready_o = {NrLanes{result_beat_o}};
  assign operand_b_ready_o = {NrLanes{result_beat_o}};

  ////////////////////
  // Queue control
  ////////////////////

  always_comb begin : p_queue
    valid_d = valid_q;

    if (result_beat_o) begin
      valid_d[write_pnt_q] = '1;
    end

    // Each lane drops its request after its grant
    for (int unsigned l = 0; l < NrLanes; l++) begin
      if (valid_q[read_pnt_q][l] && result_gnt_i[l]) begin
        valid_d[read_pnt_q][l] = 1'b0;
      end
    end

    // All lanes granted
    pop = !empty && !(|valid_d[read_pnt_q]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      write_pnt_q <= '0;
      read_pnt_q  <= '0;
      cnt_q       <= '0;
    end else begin
      valid_q <= valid_d;
      cnt_q   <= cnt_q + CntWidth'(result_beat_o) - CntWidth'(pop);
      if (result_beat_o) begin
        write_pnt_q <= (write_pnt_q == ResultQueueDepth - 1) ? '0 : write_pnt_q + 1'b1;
      end
      if (pop) begin
        read_pnt_q <= (read_pnt_q == ResultQueueDepth - 1) ? '0 : read_pnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (result_beat_o) begin
      queue_q[write_pnt_q] <= beat_entry;
    end
  end

  assign result_o     = queue_q[read_pnt_q];
  assign result_req_o = valid_q[read_pnt_q];
  assign result_pop_o = pop;

endmodule

`default_nettype wire

// File: src/masku_mask_queue.sv
`default_nettype none

module masku_mask_queue #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Held instruction
  input  masku_pkg::pe_req_t                  insn_i,
  input  logic                                insn_valid_i,
  input  masku_pkg::vlen_t                    read_cnt_i,
  // Mask operand from the lanes
  input  masku_pkg::elen_t [NrLanes-1:0]      operand_m_i,
  input  logic [NrLanes-1:0]                  operand_m_valid_i,
  output logic [NrLanes-1:0]                  operand_m_ready_o,
  // Strobes to the consumers
  output masku_pkg::strb_t [NrLanes-1:0]      mask_o,
  output logic [NrLanes-1:0]                  mask_valid_o,
  input  logic [NrLanes-1:0]                  lane_mask_ready_i,
  input  logic                                unit_mask_ready_i,
  // Progress to the controller
  output logic                                mask_beat_o,
  output logic                                mask_pop_o
);

  import masku_pkg::*;

  localparam int unsigned WordBits    = NrLanes * ELEN;
  localparam int unsigned WordBytes   = NrLanes * ELENB;
  localparam int unsigned PntWidth    = $clog2(MaskQueueDepth);
  localparam int unsigned CntWidth    = $clog2(MaskQueueDepth + 1);
  localparam int unsigned BitPntWidth = $clog2(WordBits) + 1;

  // Queue storage and per-lane valids
  strb_t [MaskQueueDepth-1:0][NrLanes-1:0] queue_q;
  logic  [MaskQueueDepth-1:0][NrLanes-1:0] valid_d, valid_q;
  logic  [PntWidth-1:0]                    write_pnt_q;
  logic  [PntWidth-1:0]                    read_pnt_q;
  logic  [CntWidth-1:0]                    cnt_q;

  // Next mask bit to use within the current operand word
  logic [BitPntWidth-1:0] mask_pnt_d, mask_pnt_q;

  logic [WordBits-1:0]   mask_flat;
  strb_t [NrLanes-1:0]   beat_strb;
  vlen_t                 beat_elems;
  logic                  active;
  logic                  full;
  logic                  empty;
  logic                  pop;

  // Only masked work of the other units needs strobes
  assign active = insn_valid_i && !insn_i.vm && insn_i.vfu != VFU_MASKU;
  assign full   = (cnt_q == MaskQueueDepth);
  assign empty  = (cnt_q == '0);

  assign mask_flat  = operand_m_i;
  assign beat_elems = vlen_t'(WordBytes >> insn_i.vsew);

  ////////////////////
  // Mask expansion
  ////////////////////

  always_comb begin : p_expand
    int unsigned elem;
    for (int unsigned b = 0; b < WordBytes; b++) begin
      // Wider elements reuse one mask bit over several bytes
      elem = b >> insn_i.vsew;
      // Elements past the vector length get no strobe
      beat_strb[b / ELENB][b % ELENB] = mask_flat[mask_pnt_q + elem] && (elem < read_cnt_i);
    end
  end

  assign mask_beat_o = active && !full && &operand_m_valid_i;

  ////////////////////
  // Queue control
  ////////////////////

  always_comb begin : p_queue
    valid_d           = valid_q;
    mask_pnt_d        = mask_pnt_q;
    operand_m_ready_o = '0;

    if (mask_beat_o) begin
      valid_d[write_pnt_q] = '1;
      mask_pnt_d           = BitPntWidth'(mask_pnt_q + beat_elems);
      // Word used up or last elements read, so release the operand
      if (mask_pnt_d == WordBits || read_cnt_i <= beat_elems) begin
        operand_m_ready_o = '1;
        mask_pnt_d        = '0;
      end
    end

    // Either the lane or the broadcast ready accepts a strobe
    for (int unsigned l = 0; l < NrLanes; l++) begin
      if (valid_q[read_pnt_q][l] && (lane_mask_ready_i[l] || unit_mask_ready_i)) begin
        valid_d[read_pnt_q][l] = 1'b0;
      end
    end

    // Entry leaves once every lane took it
    pop = !empty && !(|valid_d[read_pnt_q]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      write_pnt_q <= '0;
      read_pnt_q  <= '0;
      cnt_q       <= '0;
      mask_pnt_q  <= '0;
    end else begin
      valid_q    <= valid_d;
      mask_pnt_q <= mask_pnt_d;
      cnt_q      <= cnt_q + CntWidth'(mask_beat_o) - CntWidth'(pop);
      if (mask_beat_o) begin
        write_pnt_q <= (write_pnt_q == MaskQueueDepth - 1) ? '0 : write_pnt_q + 1'b1;
      end
      if (pop) begin
        read_pnt_q <= (read_pnt_q == MaskQueueDepth - 1) ? '0 : read_pnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mask_beat_o) begin
      queue_q[write_pnt_q] <= beat_strb;
    end
  end

  assign mask_o       = queue_q[read_pnt_q];
  assign mask_valid_o = valid_q[read_pnt_q];
  assign mask_pop_o   = pop;

endmodule

`default_nettype wire

// File: src/masku_insn_ctrl.sv
`default_nettype none

module masku_insn_ctrl #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Sequencer
  input  masku_pkg::pe_req_t            pe_req_i,
  input  logic                          pe_req_valid_i,
  output logic                          pe_req_ready_o,
  input  logic [masku_pkg::NrVInsn-1:0] pe_vinsn_running_i,
  output logic [masku_pkg::NrVInsn-1:0] pe_done_o,
  // Progress from the queues
  input  logic                          mask_beat_i,
  input  logic                          result_beat_i,
  input  logic                          mask_pop_i,
  input  logic                          result_pop_i,
  // Held instruction
  output masku_pkg::pe_req_t            insn_o,
  output logic                          insn_valid_o,
  output masku_pkg::vlen_t              read_cnt_o,
  output masku_pkg::vlen_t              issue_cnt_o
);

  import masku_pkg::*;

  // Bits in one full beat across the lanes
  localparam int unsigned WordBits = NrLanes * ELEN;

  pe_req_t            insn_q;
  logic               insn_valid_q;
  logic [NrVInsn-1:0] running_d, running_q;
  logic [NrVInsn-1:0] done_d;

  // Remaining elements in the read, issue and commit phases
  vlen_t read_cnt_d, read_cnt_q;
  vlen_t issue_cnt_d, issue_cnt_q;
  vlen_t commit_cnt_d, commit_cnt_q;

  vlen_t mask_step;
  vlen_t result_step;
  vlen_t commit_step;
  logic  accept;
  logic  commit_pop;

  // Down count that stops at zero
  function automatic vlen_t sat_sub(vlen_t cnt, vlen_t step);
    return (cnt > step) ? vlen_t'(cnt - step) : '0;
  endfunction

  // Only one instruction in flight
  assign pe_req_ready_o = !insn_valid_q;

  // Accept masked work, or anything the mask unit runs itself
  assign accept = pe_req_valid_i && pe_req_ready_o && !running_q[pe_req_i.id] &&
                  (!pe_req_i.vm || pe_req_i.vfu == VFU_MASKU);

  // Elements per mask beat depend on the element width
  assign mask_step   = vlen_t'((NrLanes * ELENB) >> insn_q.vsew);
  assign result_step = vlen_t'(WordBits);
  assign commit_step = (insn_q.vfu == VFU_MASKU) ? result_step : mask_step;
  assign commit_pop  = mask_pop_i | result_pop_i;

  always_comb begin : p_counters
    read_cnt_d   = read_cnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = '0;
    // IDs stay running only while the sequencer still flags them
    running_d    = running_q & pe_vinsn_running_i;

    if (mask_beat_i) begin
      read_cnt_d = sat_sub(read_cnt_q, mask_step);
    end
    if (result_beat_i) begin
      issue_cnt_d = sat_sub(issue_cnt_q, result_step);
    end
    if (commit_pop) begin
      commit_cnt_d = sat_sub(commit_cnt_q, commit_step);
    end

    // Last pop retires the instruction
    if (insn_valid_q && commit_pop && commit_cnt_d == '0) begin
      done_d[insn_q.id] = 1'b1;
    end

    if (accept) begin
      read_cnt_d             = pe_req_i.vl;
      issue_cnt_d            = pe_req_i.vl;
      commit_cnt_d           = pe_req_i.vl;
      running_d[pe_req_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid_q <= 1'b0;
      running_q    <= '0;
      read_cnt_q   <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      pe_done_o    <= '0;
    end else begin
      running_q    <= running_d;
      read_cnt_q   <= read_cnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      pe_done_o    <= done_d;
      if (accept) begin
        insn_valid_q <= 1'b1;
      end else if (|done_d) begin
        insn_valid_q <= 1'b0;
      end
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
  end

  assign insn_o       = insn_q;
  assign insn_valid_o = insn_valid_q;
  assign read_cnt_o   = read_cnt_q;
  assign issue_cnt_o  = issue_cnt_q;

endmodule

`default_nettype wire

// File: src/masku_pkg.sv
`default_nettype none

package masku_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Lane datapath width and bytes per lane word
  localparam int unsigned ELEN  = 64;
  localparam int unsigned ELENB = ELEN / 8;

  // Instruction IDs known to the sequencer
  localparam int unsigned NrVInsn = 8;

  // Words held by one lane for one vector register
  localparam int unsigned VRegWords = 16;

  // Largest lane count the counters must cover
  localparam int unsigned MaxLanes = 4;

  // Entries in the mask and result queues
  localparam int unsigned MaskQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [ELEN-1:0]            elen_t;
  typedef logic [ELENB-1:0]           strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Holds a full register worth of bits, including the top value itself
  typedef logic [$clog2(VRegWords*MaxLanes*ELEN):0] vlen_t;

  // Word address into the lane register file
  typedef logic [9:0] vaddr_t;

  // Element width of the instruction
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Unit that executes the instruction
  typedef enum logic [1:0] {
    VFU_ALU,
    VFU_LOAD,
    VFU_STORE,
    VFU_MASKU
  } vfu_e;

  ////////////////////
  // Structs
  ////////////////////

  // Request from the sequencer
  typedef struct packed {
    vid_t        id;
    vfu_e        vfu;
    vew_e        vsew;
    logic        vm;   // High when unmasked
    logic [4:0]  vd;
    vlen_t       vl;
  } pe_req_t;

  // One lane's register file write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

endpackage

`default_nettype wire
